/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* src.f */
verilog/scope_cmd_pkg.sv
verilog/cmd_framer.sv
verilog/info_responder.sv
verilog/spi_sequencer.sv
verilog/reply_arbiter.sv
verilog/scope_cmd_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv

/* verification/scope_cmd_stim.txt */
# name send cmd boardin ovr_mask ovr_cycles stall_cycles has_reply reply cs boardout spi_mode
# send, ovr_cycles, stall_cycles and has_reply are decimal, all other columns hex
boot          0 0000000000000000 00 0   0  0 1 0000fdfc fe 00 0
version       1 0200000000000000 00 0   0  0 1 00000013 ff 00 0
boardin_5a    1 0201000000000000 5a 0   0  0 1 5a5a5a5a ff 00 0
boardin_3c    1 0201000000000000 3c 0   0  0 1 3c3c3c3c ff 00 0
ovr_1         1 0202010000000000 00 2  37  0 1 00000025 ff 00 0
ovr_3         1 0202030000000000 00 8 100  0 1 00000064 ff 00 0
ovr_0         1 0202000000000000 00 0   0  0 1 00000000 ff 00 0
spi_cnt2      1 0305a1b2c3d40002 00 0   0  0 1 00005e4d df 00 0
spi_cnt3      1 0302112233440003 00 0   0  0 1 0000ddcc fb 00 0
spi_cnt4      1 03070ff055aa0004 00 0   0  0 1 0000aa55 7f 00 0
spi_cnt_bad   1 0301123456780009 00 0   0  0 1 0000cba9 fd 00 0
bout_set3     1 0a03010000000000 00 0   0  0 1 00000008 ff 08 0
bout_set6     1 0a06010000000000 00 0   0  0 1 00000048 ff 48 0
spi_mode      1 0402000000000000 00 0   0  0 1 00000002 ff 48 2
bout_clr3     1 0a03000000000000 00 0   0  0 1 00000040 ff 40 2
stall_info    1 0200000000000000 00 0   0 30 1 00000013 ff 40 2
stall_spi     1 0300c33c00000002 00 0   0 25 1 00003cc3 fe 40 2
unknown_op    1 0700000000000000 00 0   0  0 0 00000000 ff 40 2
after_unknown 1 0200000000000000 00 0   0  0 1 00000013 ff 40 2
info_bad_sel  1 0209000000000000 00 0   0  0 1 00000000 ff 40 2

/* verification/tb_checker.sv */
// reply checker
// takes each reply word off the stream in order and compares it, plus the
// chip select and MISO select seen during the command and the board pins,
// with the expected list

`timescale 1ns/1ps

module tb_checker (
	input  logic         clk,
	input  logic         rstn,
	input  logic         i_exp_push,       // one entry per answered command
	input  logic [127:0] i_exp_name,
	input  logic [31:0]  i_exp_reply,
	input  logic [7:0]   i_exp_cs,
	input  logic [7:0]   i_exp_boardout,
	input  logic [1:0]   i_exp_spi_mode,
	input  logic         i_reply_valid,
	input  logic         i_reply_ready,
	input  logic [31:0]  i_reply_data,
	input  logic [7:0]   i_spi_cs,
	input  logic [2:0]   i_spi_miso_sel,
	input  logic [7:0]   i_boardout,
	input  logic [1:0]   i_spi_mode,
	output int           o_seen,
	output int           o_errors
);

	logic [127:0] name_q [$];
	logic [31:0]  reply_q [$];
	logic [7:0]   cs_q [$];
	logic [7:0]   bout_q [$];
	logic [1:0]   mode_q [$];
	logic [7:0]   cs_seen;    // last chip select low since the previous reply
	logic [2:0]   miso_seen;  // MISO select while that chip was low

	function automatic int compare_field(input logic [127:0] name, input logic [63:0] field,
	                                     input logic [31:0] exp, input logic [31:0] act);
		if (exp === act)
			return 0;
		$display("FAILED %0s %0s: expected %h, actual %h", name, field, exp, act);
		return 1;
	endfunction

	always @(posedge clk) begin : compare
		int           bad;
		logic [127:0] name;
		logic [31:0]  exp_reply;
		logic [7:0]   exp_cs;
		logic [7:0]   exp_bout;
		logic [1:0]   exp_mode;
		logic [2:0]   exp_miso;
		bad = 0;
		if (!rstn) begin
			o_seen    <= 0;
			o_errors  <= 0;
			cs_seen   <= 8'hff;
			miso_seen <= 3'd0;
		end else begin
			if (i_exp_push) begin
				name_q.push_back(i_exp_name);
				reply_q.push_back(i_exp_reply);
				cs_q.push_back(i_exp_cs);
				bout_q.push_back(i_exp_boardout);
				mode_q.push_back(i_exp_spi_mode);
			end
			if (i_spi_cs != 8'hff) begin
				cs_seen   <= i_spi_cs;  // remember which chip was addressed
				miso_seen <= i_spi_miso_sel;
			end
			if (i_reply_valid && i_reply_ready) begin
				if (reply_q.size() == 0) begin
					$display("reply %h arrived while no command was waiting for one", i_reply_data);
					bad = 1;
				end else begin
					name      = name_q.pop_front();
					exp_reply = reply_q.pop_front();
					exp_cs    = cs_q.pop_front();
					exp_bout  = bout_q.pop_front();
					exp_mode  = mode_q.pop_front();
					exp_miso  = 3'd0;
					for (int k = 0; k < 8; k++) begin
						if (!exp_cs[k])
							exp_miso = 3'(k);  // chip index from the low select bit
					end
					bad += compare_field(name, "reply", exp_reply, i_reply_data);
					bad += compare_field(name, "cs", {24'd0, exp_cs}, {24'd0, cs_seen});
					bad += compare_field(name, "cs_idle", 32'h000000ff, {24'd0, i_spi_cs});
					if (exp_cs != 8'hff)
						bad += compare_field(name, "miso_sel", {29'd0, exp_miso},
						                     {29'd0, miso_seen});
					bad += compare_field(name, "boardout", {24'd0, exp_bout}, {24'd0, i_boardout});
					bad += compare_field(name, "spi_mode", {30'd0, exp_mode}, {30'd0, i_spi_mode});
				end
				cs_seen <= 8'hff;
				o_seen  <= o_seen + 1;
			end
			o_errors <= o_errors + bad;
		end
	end

endmodule

/* verification/tb_clock.sv */
// testbench clock and reset
// 100 ns clock, reset held low for the first 5 cycles

`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rstn
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // half of the 100 ns period
	end

	initial begin
		rstn = 1'b0;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
	end

endmodule

/* verification/tb_top.sv */
// testbench top
// replays the stim file into the command path, models the SPI master and
// chip, and stalls the reply stream at random

`timescale 1ns/1ps

module tb_top;

	localparam int WAIT_LIMIT   = 5000;  // cycles allowed for any one wait
	localparam int QUIET_CYCLES = 20;    // window for a reply that must not come

	logic         clk, rstn;
	logic         rx_valid, rx_ready;
	logic [7:0]   rx_data;
	logic [7:0]   boardin, boardout;
	logic [3:0]   overrange;
	logic [1:0]   spi_mode;
	logic [7:0]   spi_tx, spi_rx, spi_cs;
	logic         spi_tx_dv, spi_tx_ready, spi_rx_dv;
	logic [2:0]   spi_miso_sel;
	logic         reply_valid, reply_ready;
	logic [31:0]  reply_data;
	logic         stall;     // forces reply ready low
	logic         exp_push;
	logic [127:0] exp_name;
	logic [31:0]  exp_reply;
	logic [7:0]   exp_cs, exp_bout;
	logic [1:0]   exp_mode;
	int           seen, errors;
	int           run_errors;  // timeouts and file trouble
	int           expected;    // replies expected so far

	tb_clock clock_i (.clk(clk), .rstn(rstn));

	scope_cmd_top scope_cmd_top_i (
		.clk(clk), .rstn(rstn),
		.i_rx_valid(rx_valid), .i_rx_data(rx_data), .o_rx_ready(rx_ready),
		.i_boardin(boardin), .i_overrange(overrange),
		.o_boardout(boardout), .o_spi_mode(spi_mode),
		.o_spi_tx(spi_tx), .o_spi_tx_dv(spi_tx_dv), .i_spi_tx_ready(spi_tx_ready),
		.i_spi_rx(spi_rx), .i_spi_rx_dv(spi_rx_dv),
		.o_spi_cs(spi_cs), .o_spi_miso_sel(spi_miso_sel),
		.o_reply_valid(reply_valid), .i_reply_ready(reply_ready), .o_reply_data(reply_data)
	);

	tb_checker checker_i (
		.clk(clk), .rstn(rstn),
		.i_exp_push(exp_push), .i_exp_name(exp_name), .i_exp_reply(exp_reply),
		.i_exp_cs(exp_cs), .i_exp_boardout(exp_bout), .i_exp_spi_mode(exp_mode),
		.i_reply_valid(reply_valid), .i_reply_ready(reply_ready), .i_reply_data(reply_data),
		.i_spi_cs(spi_cs), .i_spi_miso_sel(spi_miso_sel),
		.i_boardout(boardout), .i_spi_mode(spi_mode),
		.o_seen(seen), .o_errors(errors)
	);

	// ------------------------------
	// host side helpers
	// ------------------------------
	task automatic send_byte(input logic [7:0] b);
		int n;
		n = 0;
		if (run_errors == 0) begin
			rx_valid <= 1'b1;
			rx_data  <= b;
			@(posedge clk);
			while (!rx_ready && n < WAIT_LIMIT) begin  // byte moves on valid and ready
				@(posedge clk);
				n++;
			end
			if (!rx_ready) begin
				$display("timeout: the framer never accepted byte %h", b);
				run_errors++;
			end
		end
	endtask

	task automatic wait_reply_valid();
		int n;
		n = 0;
		while (!reply_valid && n < WAIT_LIMIT && run_errors == 0) begin
			@(posedge clk);
			n++;
		end
		if (!reply_valid && run_errors == 0) begin
			$display("timeout: no reply word showed up under back-pressure");
			run_errors++;
		end
	endtask

	task automatic wait_replies(input int count);
		int n;
		n = 0;
		while (seen < count && n < WAIT_LIMIT && run_errors == 0) begin
			@(posedge clk);
			n++;
		end
		if (seen < count && run_errors == 0) begin
			$display("timeout: reply number %0d never arrived", count);
			run_errors++;
		end
	endtask

	// SPI master and chip model that returns each byte inverted after 1 to 4 cycles
	initial begin : spi_model
		logic [7:0] sent;
		int         delay;
		spi_tx_ready = 1'b1;
		spi_rx       = 8'h00;
		spi_rx_dv    = 1'b0;
		forever begin
			@(posedge clk);
			spi_rx_dv <= 1'b0;
			if (spi_tx_dv) begin
				sent  = spi_tx;
				delay = 1 + ($urandom % 4);
				spi_tx_ready <= 1'b0;
				repeat (delay) @(posedge clk);
				spi_rx       <= ~sent;
				spi_rx_dv    <= 1'b1;
				spi_tx_ready <= 1'b1;
			end
		end
	end

	// reply ready toggles in random spans unless a stall is forced
	initial begin : ready_driver
		logic level;
		int   span;
		level       = 1'b1;
		reply_ready = 1'b0;
		forever begin
			span = 1 + ($urandom % 6);
			repeat (span) begin
				@(posedge clk);
				reply_ready <= level && !stall;
			end
			level = !level;
		end
	end

	// ------------------------------
	// stim file replay
	// ------------------------------
	initial begin : main
		int               fd, got, n, i;
		int               send, ovr_cycles, stall_cycles, has_reply;
		logic [8*200-1:0] line;
		logic [127:0]     name;
		logic [63:0]      cmd;
		logic [7:0]       bin, cs, bout;
		logic [3:0]       ovr_mask;
		logic [31:0]      reply;
		logic [1:0]       mode;
		void'($urandom(86048));
		rx_valid   = 1'b0;
		rx_data    = 8'h00;
		boardin    = 8'h00;
		overrange  = 4'd0;
		stall      = 1'b0;
		exp_push   = 1'b0;
		exp_name   = '0;
		exp_reply  = '0;
		exp_cs     = 8'hff;
		exp_bout   = 8'h00;
		exp_mode   = 2'd0;
		run_errors = 0;
		expected   = 0;
		fd = $fopen("verification/scope_cmd_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stim file");
			run_errors++;
		end
		n = 0;
		while (rstn !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (rstn !== 1'b1) begin
			$display("timeout: reset was never released");
			run_errors++;
		end
		while (fd != 0 && !$feof(fd) && run_errors == 0) begin
			line = '0;
			n = $fgets(line, fd);
			got = $sscanf(line, "%s %d %h %h %h %d %d %d %h %h %h %h", name, send, cmd, bin,
			              ovr_mask, ovr_cycles, stall_cycles, has_reply, reply, cs, bout, mode);
			if (got == 12) begin  // comment and blank lines fall through
				boardin <= bin;
				if (ovr_cycles > 0) begin
					overrange <= ovr_mask;
					repeat (ovr_cycles) @(posedge clk);  // one counted cycle per edge
					overrange <= 4'd0;
				end
				if (has_reply != 0) begin
					exp_name  <= name;
					exp_reply <= reply;
					exp_cs    <= cs;
					exp_bout  <= bout;
					exp_mode  <= mode;
					exp_push  <= 1'b1;
					@(posedge clk);
					exp_push  <= 1'b0;
					expected++;
				end
				if (stall_cycles > 0)
					stall <= 1'b1;
				if (send != 0) begin
					for (i = 7; i >= 0; i--)
						send_byte(cmd[i*8 +: 8]);  // opcode byte first
					rx_valid <= 1'b0;
				end
				if (stall_cycles > 0) begin
					wait_reply_valid();
					repeat (stall_cycles) @(posedge clk);
					stall <= 1'b0;
				end
				if (has_reply != 0)
					wait_replies(expected);
				else
					repeat (QUIET_CYCLES) @(posedge clk);
			end
		end
		repeat (QUIET_CYCLES) @(posedge clk);  // room for a duplicate reply to show
		if (fd != 0)
			$fclose(fd);
		$display("replies checked: %0d of %0d, mismatches: %0d, run errors: %0d",
		         seen, expected, errors, run_errors);
		if (errors == 0 && run_errors == 0 && seen == expected && expected > 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* verilog/cmd_framer.sv */
// command framer
// assembles 8 host bytes into one command word and hands it to the
// info or SPI engine by opcode, unknown opcodes are dropped

`timescale 1ns/1ps

module cmd_framer (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     i_rx_valid,
	input  logic [7:0]               i_rx_data,
	output logic                     o_rx_ready,
	output scope_cmd_pkg::cmd_word_u o_cmd,
	output logic                     o_info_valid,
	input  logic                     i_info_ready,
	output logic                     o_spi_valid,
	input  logic                     i_spi_ready
);

	logic [2:0]  byte_cnt;   // bytes of the current command so far
	logic [63:0] next_word;  // word including the byte on the bus
	logic [7:0]  next_op;
	logic        rx_take;
	logic        last_byte;

	assign rx_take    = i_rx_valid && o_rx_ready;
	assign last_byte  = rx_take && (byte_cnt == 3'(scope_cmd_pkg::CMD_BYTES - 1));
	assign next_word  = {o_cmd[55:0], i_rx_data};  // shift in from the bottom
	assign next_op    = next_word[63:56];
	assign o_rx_ready = !(o_info_valid || o_spi_valid);  // stall while a command waits

	always_ff @(posedge clk) begin
		if (rx_take)
			o_cmd <= next_word;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt     <= 3'd0;
			o_info_valid <= 1'b0;
			o_spi_valid  <= 1'b0;
		end else begin
			if (last_byte)
				byte_cnt <= 3'd0;
			else if (rx_take)
				byte_cnt <= byte_cnt + 3'd1;

			if (last_byte) begin
				case (next_op)
					scope_cmd_pkg::OP_SPI:       o_spi_valid  <= 1'b1;
					scope_cmd_pkg::OP_INFO,
					scope_cmd_pkg::OP_SPI_MODE,
					scope_cmd_pkg::OP_BOARDOUT:  o_info_valid <= 1'b1;
					default:                     ; // unknown, no reply
				endcase
			end

			if (o_info_valid && i_info_ready)
				o_info_valid <= 1'b0;
			if (o_spi_valid && i_spi_ready)
				o_spi_valid <= 1'b0;
		end
	end

	// one command goes to one engine only
	a_one_route: assert property (@(posedge clk) disable iff (!rstn)
		!(o_info_valid && o_spi_valid));

endmodule

/* verilog/info_responder.sv */
// info engine
// answers version, board input and overrange counter reads, sets the
// SPI mode and single board output bits, one reply word per command

`timescale 1ns/1ps

module info_responder (
	input  logic                                clk,
	input  logic                                rstn,
	input  logic                                i_cmd_valid,
	output logic                                o_cmd_ready,
	input  scope_cmd_pkg::cmd_word_u            i_cmd,
	input  logic [7:0]                          i_boardin,
	input  logic [3:0]                          i_overrange,
	output logic [7:0]                          o_boardout,
	output logic [1:0]                          o_spi_mode,
	output logic                                o_reply_valid,
	input  logic                                i_reply_ready,
	output logic [scope_cmd_pkg::REPLY_W-1:0]   o_reply_data
);

	logic [31:0] ovr_cnt [4];   // cycles each overrange bit was high
	logic [7:0]  bout_next;     // board output with the commanded bit applied
	logic [scope_cmd_pkg::REPLY_W-1:0] reply_next;
	logic        cmd_take;

	assign o_cmd_ready = !o_reply_valid;  // one command in flight
	assign cmd_take    = i_cmd_valid && o_cmd_ready;

	// ------------------------------
	// reply decode
	// ------------------------------
	always_comb begin
		bout_next = o_boardout;
		bout_next[i_cmd.generic.arg1[2:0]] = i_cmd.generic.arg2[0];
		reply_next = '0;
		case (i_cmd.generic.opcode)
			scope_cmd_pkg::OP_INFO: begin
				case (i_cmd.generic.arg1)
					scope_cmd_pkg::INFO_VERSION:   reply_next = scope_cmd_pkg::FW_VERSION;
					scope_cmd_pkg::INFO_BOARDIN:   reply_next = {4{i_boardin}};
					scope_cmd_pkg::INFO_OVERRANGE: reply_next = ovr_cnt[i_cmd.generic.arg2[1:0]];
					default:                       reply_next = '0;  // undefined selector
				endcase
			end
			scope_cmd_pkg::OP_SPI_MODE: reply_next = {24'd0, i_cmd.generic.arg1};  // echo
			scope_cmd_pkg::OP_BOARDOUT: reply_next = {24'd0, bout_next};
			default:                    reply_next = '0;
		endcase
	end

	// ------------------------------
	// state and counters
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_reply_valid <= 1'b0;
			o_spi_mode    <= 2'd0;
			o_boardout    <= 8'd0;
			for (int i = 0; i < 4; i++)
				ovr_cnt[i] <= 32'd0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (i_overrange[i])
					ovr_cnt[i] <= ovr_cnt[i] + 32'd1;
			end

			if (cmd_take) begin
				o_reply_valid <= 1'b1;
				if (i_cmd.generic.opcode == scope_cmd_pkg::OP_SPI_MODE)
					o_spi_mode <= i_cmd.generic.arg1[1:0];
				if (i_cmd.generic.opcode == scope_cmd_pkg::OP_BOARDOUT)
					o_boardout <= bout_next;
			end else if (o_reply_valid && i_reply_ready) begin
				o_reply_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take)
			o_reply_data <= reply_next;  // captured with the command
	end

endmodule

/* verilog/reply_arbiter.sv */
// reply arbiter
// shares the outgoing reply word stream between the info and SPI engines

`timescale 1ns/1ps

module reply_arbiter (
	input  logic                                clk,
	input  logic                                rstn,
	input  logic                                i_info_valid,
	output logic                                o_info_ready,
	input  logic [scope_cmd_pkg::REPLY_W-1:0]   i_info_data,
	input  logic                                i_spi_valid,
	output logic                                o_spi_ready,
	input  logic [scope_cmd_pkg::REPLY_W-1:0]   i_spi_data,
	output logic                                o_reply_valid,
	input  logic                                i_reply_ready,
	output logic [scope_cmd_pkg::REPLY_W-1:0]   o_reply_data
);

	logic age_info;   // info request already waited a cycle
	logic age_spi;
	logic can_load;
	logic pick_info;

	assign can_load     = !o_reply_valid;  // grant only into an empty register
	assign pick_info    = i_info_valid && (!i_spi_valid || (age_info && !age_spi));  // tie to spi
	assign o_info_ready = can_load && pick_info;
	assign o_spi_ready  = can_load && i_spi_valid && !pick_info;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			age_info      <= 1'b0;
			age_spi       <= 1'b0;
			o_reply_valid <= 1'b0;
		end else begin
			age_info <= i_info_valid && !o_info_ready;
			age_spi  <= i_spi_valid && !o_spi_ready;
			if (o_info_ready || o_spi_ready)
				o_reply_valid <= 1'b1;
			else if (i_reply_ready)
				o_reply_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (o_info_ready)
			o_reply_data <= i_info_data;
		else if (o_spi_ready)
			o_reply_data <= i_spi_data;
	end

	// a stalled word stays put until the host takes it
	a_hold: assert property (@(posedge clk) disable iff (!rstn)
		(o_reply_valid && !i_reply_ready) |=> (o_reply_valid && $stable(o_reply_data)));

endmodule

/* verilog/scope_cmd_pkg.sv */
// scope command path shared definitions
// opcodes, protocol widths, SPI timing and the 8-byte command word

package scope_cmd_pkg;

	// ------------------------------
	// opcodes and info selectors
	// ------------------------------
	localparam logic [7:0] OP_INFO     = 8'd2;   // register and status reads
	localparam logic [7:0] OP_SPI      = 8'd3;   // chip transaction
	localparam logic [7:0] OP_SPI_MODE = 8'd4;   // SPI master mode
	localparam logic [7:0] OP_BOARDOUT = 8'd10;  // single board output bit

	localparam logic [7:0] INFO_VERSION   = 8'd0;
	localparam logic [7:0] INFO_BOARDIN   = 8'd1;
	localparam logic [7:0] INFO_OVERRANGE = 8'd2;

	localparam logic [31:0] FW_VERSION = 32'd19;

	// ------------------------------
	// protocol and SPI timing
	// ------------------------------
	localparam int CMD_BYTES       = 8;    // bytes per host command
	localparam int REPLY_W         = 32;   // reply word width
	localparam int CS_SETUP_CYCLES = 10;   // cs low to first byte
	localparam int CS_HOLD_CYCLES  = 35;   // last rx byte to cs high

	// boot transaction, powers down the ADC
	localparam logic [7:0] BOOT_CHIP = 8'd0;
	localparam logic [7:0] BOOT_B0   = 8'h00;
	localparam logic [7:0] BOOT_B1   = 8'h02;
	localparam logic [7:0] BOOT_B2   = 8'h03;

	// SPI transaction FSM states
	localparam logic [2:0] SPI_IDLE    = 3'd0;
	localparam logic [2:0] SPI_SETUP   = 3'd1;
	localparam logic [2:0] SPI_SEND    = 3'd2;
	localparam logic [2:0] SPI_WAIT_RX = 3'd3;
	localparam logic [2:0] SPI_HOLD    = 3'd4;
	localparam logic [2:0] SPI_REPLY   = 3'd5;

	// first received byte sits in the top byte of the word
	typedef union packed {
		struct packed {
			logic [7:0] opcode;
			logic [7:0] arg1;
			logic [7:0] arg2;
			logic [7:0] arg3;
			logic [7:0] arg4;
			logic [7:0] arg5;
			logic [7:0] arg6;
			logic [7:0] arg7;
		} generic;
		struct packed {
			logic [7:0]  opcode;
			logic [7:0]  chip;     // chip select index
			logic [31:0] payload;  // payload byte 0 in the top byte
			logic [7:0]  spare;
			logic [7:0]  count;    // bytes to send, 2..4
		} spi;
	} cmd_word_u;

endpackage

/* verilog/scope_cmd_top.sv */
// scope command path top
// host byte stream in, reply word stream out, SPI master and board pins

`timescale 1ns/1ps

module scope_cmd_top (
	input  logic                                clk,
	input  logic                                rstn,
	input  logic                                i_rx_valid,
	input  logic [7:0]                          i_rx_data,
	output logic                                o_rx_ready,
	input  logic [7:0]                          i_boardin,
	input  logic [3:0]                          i_overrange,
	output logic [7:0]                          o_boardout,
	output logic [1:0]                          o_spi_mode,
	output logic [7:0]                          o_spi_tx,
	output logic                                o_spi_tx_dv,
	input  logic                                i_spi_tx_ready,
	input  logic [7:0]                          i_spi_rx,
	input  logic                                i_spi_rx_dv,
	output logic [7:0]                          o_spi_cs,
	output logic [2:0]                          o_spi_miso_sel,
	output logic                                o_reply_valid,
	input  logic                                i_reply_ready,
	output logic [scope_cmd_pkg::REPLY_W-1:0]   o_reply_data
);

	scope_cmd_pkg::cmd_word_u           cmd;
	logic                               info_cmd_valid, info_cmd_ready;
	logic                               spi_cmd_valid, spi_cmd_ready;
	logic                               info_rep_valid, info_rep_ready;
	logic                               spi_rep_valid, spi_rep_ready;
	logic [scope_cmd_pkg::REPLY_W-1:0]  info_rep_data;
	logic [scope_cmd_pkg::REPLY_W-1:0]  spi_rep_data;

	cmd_framer framer_i (
		.clk(clk), .rstn(rstn),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .o_rx_ready(o_rx_ready),
		.o_cmd(cmd),
		.o_info_valid(info_cmd_valid), .i_info_ready(info_cmd_ready),
		.o_spi_valid(spi_cmd_valid), .i_spi_ready(spi_cmd_ready)
	);

	info_responder info_i (
		.clk(clk), .rstn(rstn),
		.i_cmd_valid(info_cmd_valid), .o_cmd_ready(info_cmd_ready), .i_cmd(cmd),
		.i_boardin(i_boardin), .i_overrange(i_overrange),
		.o_boardout(o_boardout), .o_spi_mode(o_spi_mode),
		.o_reply_valid(info_rep_valid), .i_reply_ready(info_rep_ready),
		.o_reply_data(info_rep_data)
	);

	spi_sequencer spi_i (
		.clk(clk), .rstn(rstn),
		.i_cmd_valid(spi_cmd_valid), .o_cmd_ready(spi_cmd_ready), .i_cmd(cmd),
		.o_spi_tx(o_spi_tx), .o_spi_tx_dv(o_spi_tx_dv), .i_spi_tx_ready(i_spi_tx_ready),
		.i_spi_rx(i_spi_rx), .i_spi_rx_dv(i_spi_rx_dv),
		.o_spi_cs(o_spi_cs), .o_spi_miso_sel(o_spi_miso_sel),
		.o_reply_valid(spi_rep_valid), .i_reply_ready(spi_rep_ready),
		.o_reply_data(spi_rep_data)
	);

	reply_arbiter arbiter_i (
		.clk(clk), .rstn(rstn),
		.i_info_valid(info_rep_valid), .o_info_ready(info_rep_ready),
		.i_info_data(info_rep_data),
		.i_spi_valid(spi_rep_valid), .o_spi_ready(spi_rep_ready),
		.i_spi_data(spi_rep_data),
		.o_reply_valid(o_reply_valid), .i_reply_ready(i_reply_ready),
		.o_reply_data(o_reply_data)
	);

endmodule

/* verilog/spi_sequencer.sv */
// SPI engine
// runs the ADC power-down boot transaction once, then host chip
// transactions, byte by byte through an external SPI master

`timescale 1ns/1ps

module spi_sequencer (
	input  logic                                clk,
	input  logic                                rstn,
	input  logic                                i_cmd_valid,
	output logic                                o_cmd_ready,
	input  scope_cmd_pkg::cmd_word_u            i_cmd,
	output logic [7:0]                          o_spi_tx,
	output logic                                o_spi_tx_dv,
	input  logic                                i_spi_tx_ready,
	input  logic [7:0]                          i_spi_rx,
	input  logic                                i_spi_rx_dv,
	output logic [7:0]                          o_spi_cs,
	output logic [2:0]                          o_spi_miso_sel,
	output logic                                o_reply_valid,
	input  logic                                i_reply_ready,
	output logic [scope_cmd_pkg::REPLY_W-1:0]   o_reply_data
);

	logic [2:0]  state;
	logic        boot_done;   // boot transaction already started
	logic [5:0]  wait_cnt;    // cs setup and hold timer
	logic [2:0]  left;        // bytes still to send
	logic [31:0] tx_sh;       // payload, next byte on top
	logic [15:0] rx_sh;       // last two received bytes

	logic [2:0]  ld_chip;
	logic [31:0] ld_payload;
	logic [2:0]  ld_count;
	logic        start;
	logic        setup_done;
	logic        hold_done;
	logic        tx_go;
	logic        rx_got;
	logic        in_txn;

	assign o_cmd_ready = (state == scope_cmd_pkg::SPI_IDLE) && boot_done;
	assign start       = (state == scope_cmd_pkg::SPI_IDLE) && (!boot_done || i_cmd_valid);
	assign setup_done  = (state == scope_cmd_pkg::SPI_SETUP) &&
	                     (wait_cnt == 6'(scope_cmd_pkg::CS_SETUP_CYCLES - 1));
	assign hold_done   = (state == scope_cmd_pkg::SPI_HOLD) &&
	                     (wait_cnt == 6'(scope_cmd_pkg::CS_HOLD_CYCLES - 1));
	assign tx_go       = (state == scope_cmd_pkg::SPI_SEND) && i_spi_tx_ready;
	assign rx_got      = (state == scope_cmd_pkg::SPI_WAIT_RX) && i_spi_rx_dv;

	// boot has priority over host commands
	always_comb begin
		if (!boot_done) begin
			ld_chip    = scope_cmd_pkg::BOOT_CHIP[2:0];
			ld_payload = {scope_cmd_pkg::BOOT_B0, scope_cmd_pkg::BOOT_B1,
			              scope_cmd_pkg::BOOT_B2, 8'h00};
			ld_count   = 3'd3;
		end else begin
			ld_chip    = i_cmd.spi.chip[2:0];
			ld_payload = i_cmd.spi.payload;
			case (i_cmd.spi.count)
				8'd2, 8'd3, 8'd4: ld_count = i_cmd.spi.count[2:0];
				default:          ld_count = 3'd3;  // bad count, send three
			endcase
		end
	end

	// ------------------------------
	// transaction FSM
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= scope_cmd_pkg::SPI_IDLE;
			boot_done      <= 1'b0;
			wait_cnt       <= 6'd0;
			left           <= 3'd0;
			o_spi_tx_dv    <= 1'b0;
			o_spi_cs       <= 8'hff;
			o_spi_miso_sel <= 3'd0;
			o_reply_valid  <= 1'b0;
		end else begin
			o_spi_tx_dv <= 1'b0;  // single cycle strobe
			case (state)
				scope_cmd_pkg::SPI_IDLE: begin
					if (start) begin
						boot_done      <= 1'b1;
						o_spi_cs       <= ~(8'h01 << ld_chip);
						o_spi_miso_sel <= ld_chip;
						left           <= ld_count;
						wait_cnt       <= 6'd0;
						state          <= scope_cmd_pkg::SPI_SETUP;
					end
				end
				scope_cmd_pkg::SPI_SETUP: begin
					if (setup_done) begin
						wait_cnt <= 6'd0;
						state    <= scope_cmd_pkg::SPI_SEND;
					end else begin
						wait_cnt <= wait_cnt + 6'd1;
					end
				end
				scope_cmd_pkg::SPI_SEND: begin
					if (tx_go) begin
						o_spi_tx_dv <= 1'b1;
						left        <= left - 3'd1;
						state       <= scope_cmd_pkg::SPI_WAIT_RX;
					end
				end
				scope_cmd_pkg::SPI_WAIT_RX: begin
					if (rx_got)  // one rx byte per tx byte
						state <= (left == 3'd0) ? scope_cmd_pkg::SPI_HOLD : scope_cmd_pkg::SPI_SEND;
				end
				scope_cmd_pkg::SPI_HOLD: begin
					if (hold_done) begin
						wait_cnt      <= 6'd0;
						o_spi_cs      <= 8'hff;
						o_reply_valid <= 1'b1;
						state         <= scope_cmd_pkg::SPI_REPLY;
					end else begin
						wait_cnt <= wait_cnt + 6'd1;
					end
				end
				scope_cmd_pkg::SPI_REPLY: begin
					if (i_reply_ready) begin
						o_reply_valid <= 1'b0;
						state         <= scope_cmd_pkg::SPI_IDLE;
					end
				end
				default: state <= scope_cmd_pkg::SPI_IDLE;
			endcase
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (start)
			tx_sh <= ld_payload;
		if (tx_go) begin
			o_spi_tx <= tx_sh[31:24];
			tx_sh    <= {tx_sh[23:0], 8'h00};
		end
		if (rx_got)
			rx_sh <= {rx_sh[7:0], i_spi_rx};
		if (hold_done)
			o_reply_data <= {16'd0, rx_sh};
	end

	assign in_txn = (state == scope_cmd_pkg::SPI_SETUP) || (state == scope_cmd_pkg::SPI_SEND) ||
	                (state == scope_cmd_pkg::SPI_WAIT_RX) || (state == scope_cmd_pkg::SPI_HOLD);

	// at most one chip selected, and the selection holds for the whole transaction
	a_cs_onehot: assert property (@(posedge clk) disable iff (!rstn)
		$onehot0(~o_spi_cs));
	a_cs_stable: assert property (@(posedge clk) disable iff (!rstn)
		(in_txn && $past(in_txn)) |-> $stable(o_spi_cs));

endmodule
